//--- hdl/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// number of execute lanes, 2, 4 or 8
`define EXEC_LANES 4

// apb side
`define EXEC_ADDR_W 8
`define EXEC_DATA_W 32

// operand width, two apb words per operand
`define EXEC_XLEN 64

// shift-add iterations per multiply
`define MUL_STEPS 64

`endif

//--- hdl/exec_pkg.sv
package exec_pkg;

    // control word bits 4:0
    typedef enum logic [4:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        AND  = 5'd2,
        OR   = 5'd3,
        XOR  = 5'd4,
        SLL  = 5'd5,
        SRL  = 5'd6,
        SRA  = 5'd7,
        SLT  = 5'd8,
        SLTU = 5'd9,
        DIVU = 5'd10,
        REMU = 5'd11,
        MUL  = 5'd12,
        MEM  = 5'd13,  // narrowing pass of operand 2
        CEQ  = 5'd14,
        CNE  = 5'd15,
        CLT  = 5'd16,
        CLTU = 5'd17,
        CGE  = 5'd18,
        CGEU = 5'd19
    } alu_op_e;

    typedef enum logic {
        W64 = 1'b0,
        W32 = 1'b1  // low word of operand 1, 5-bit shamt
    } width_e;

    typedef enum logic [1:0] {
        EXT_NONE   = 2'd0,
        EXT_SEXT32 = 2'd1,
        EXT_ZEXT32 = 2'd2,
        EXT_SEXT16 = 2'd3
    } ext_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } mul_state_e;

endpackage

//--- hdl/lane_if.sv
`timescale 1ns/1ps
`include "exec_params.svh"

// dispatcher to lane command
interface lane_cmd_if
    import exec_pkg::*;
();
    logic                   start;  // one-cycle pulse
    alu_op_e                op;
    width_e                 width;
    ext_e                   ext;
    logic [`EXEC_XLEN-1:0]  src1;
    logic [`EXEC_XLEN-1:0]  src2;
    logic                   busy;

    modport disp (output start, op, width, ext, src1, src2, input busy);
    modport lane (input start, op, width, ext, src1, src2, output busy);
endinterface

// lane to collector result, clear acks done
interface lane_res_if;
    logic                   done;
    logic                   busy;
    logic [`EXEC_XLEN-1:0]  result;
    logic                   flag;
    logic                   clear;

    modport lane (output done, busy, result, flag, input clear);
    modport coll (input done, busy, result, flag, output clear);
endinterface

//--- hdl/apb_dispatch.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module apb_dispatch
    import exec_pkg::*;
#(
    parameter int LANE_W = $clog2(`EXEC_LANES)
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`EXEC_ADDR_W-1:0] paddr,
    input  logic [`EXEC_DATA_W-1:0] pwdata,
    output logic                    pready,
    output logic                    pslverr,
    lane_cmd_if.disp                cmd [`EXEC_LANES],
    output logic [LANE_W-1:0]       rd_lane,
    output logic [2:0]              rd_reg,
    output logic                    rd_en
);

    localparam int HI_W = `EXEC_ADDR_W - 5;

    logic [HI_W-1:0]        lane_hi;
    logic [LANE_W-1:0]      lane;
    logic [2:0]             word;  // word index in the 32-byte window
    logic                   lane_ok;
    logic                   access;
    logic                   wr;
    logic                   ctrl_wr;
    logic [`EXEC_LANES-1:0] busy_v;
    logic [`EXEC_LANES-1:0] start_q;
    alu_op_e                op_q    [`EXEC_LANES];
    width_e                 width_q [`EXEC_LANES];
    ext_e                   ext_q   [`EXEC_LANES];
    logic [`EXEC_XLEN-1:0]  src1_q  [`EXEC_LANES];
    logic [`EXEC_XLEN-1:0]  src2_q  [`EXEC_LANES];

    assign lane_hi = paddr[`EXEC_ADDR_W-1:5];
    assign lane    = paddr[5 +: LANE_W];
    assign word    = paddr[4:2];
    assign lane_ok = 32'(lane_hi) < `EXEC_LANES;  // windows above the last lane unmapped

    assign access  = psel & penable & lane_ok;
    assign wr      = access & pwrite;
    assign ctrl_wr = wr & (word == 3'd0);

    assign pready  = 1'b1;  // no wait states
    assign pslverr = ctrl_wr & busy_v[lane];

    assign rd_en   = access & ~pwrite;
    assign rd_lane = lane;
    assign rd_reg  = word;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_q <= '0;
        end else begin
            for (int i = 0; i < `EXEC_LANES; i++) begin
                start_q[i] <= ctrl_wr && (lane == LANE_W'(i)) && !busy_v[i];
            end
        end
    end

    // holding registers, operands go out with start
    always_ff @(posedge clk) begin
        for (int i = 0; i < `EXEC_LANES; i++) begin
            if (wr && lane == LANE_W'(i)) begin
                case (word)
                    3'd0: begin
                        if (!busy_v[i]) begin
                            op_q[i]    <= alu_op_e'(pwdata[4:0]);
                            width_q[i] <= width_e'(pwdata[8]);
                            ext_q[i]   <= ext_e'(pwdata[13:12]);
                        end
                    end
                    3'd2: src1_q[i][31:0]  <= pwdata;
                    3'd3: src1_q[i][63:32] <= pwdata;
                    3'd4: src2_q[i][31:0]  <= pwdata;
                    3'd5: src2_q[i][63:32] <= pwdata;
                    default: ;  // status and result are read only
                endcase
            end
        end
    end

    for (genvar g = 0; g < `EXEC_LANES; g++) begin : g_cmd
        assign cmd[g].start = start_q[g];
        assign cmd[g].op    = op_q[g];
        assign cmd[g].width = width_q[g];
        assign cmd[g].ext   = ext_q[g];
        assign cmd[g].src1  = src1_q[g];
        assign cmd[g].src2  = src2_q[g];
        assign busy_v[g]    = cmd[g].busy;
    end

endmodule

//--- hdl/shift_add_mul.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module shift_add_mul
    import exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  go,
    input  logic [`EXEC_XLEN-1:0] multiplicand,
    input  logic [`EXEC_XLEN-1:0] multiplier,
    output logic [`EXEC_XLEN-1:0] product,
    output logic                  finish
);

    localparam int CNT_W = $clog2(`MUL_STEPS) + 1;

    mul_state_e            state;
    logic [CNT_W-1:0]      step_q;
    logic [`EXEC_XLEN-1:0] mcand_q;   // shifts left each step
    logic [`EXEC_XLEN-1:0] mplier_q;  // shifts right, lsb picks the add
    logic [`EXEC_XLEN-1:0] acc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            step_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (go) begin
                        state  <= RUN;
                        step_q <= '0;
                    end
                end
                RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == CNT_W'(`MUL_STEPS - 1))
                        state <= DONE;
                end
                DONE:    state <= IDLE;  // finish lasts one cycle
                default: state <= IDLE;
            endcase
        end
    end

    // go outside IDLE is ignored
    always_ff @(posedge clk) begin
        if (state == IDLE && go) begin
            mcand_q  <= multiplicand;
            mplier_q <= multiplier;
            acc_q    <= '0;
        end else if (state == RUN) begin
            if (mplier_q[0])
                acc_q <= acc_q + mcand_q;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    // low half only
    assign product = acc_q;
    assign finish  = (state == DONE);

endmodule

//--- hdl/exec_lane.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_lane
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    lane_cmd_if.lane cmd,
    lane_res_if.lane res
);

    logic [`EXEC_XLEN-1:0] a_in;
    logic [`EXEC_XLEN-1:0] a_q;
    logic [`EXEC_XLEN-1:0] b_q;
    logic [`EXEC_XLEN-1:0] alu_res;
    logic [`EXEC_XLEN-1:0] product;
    logic [`EXEC_XLEN-1:0] result_q;
    alu_op_e               op_q;
    width_e                width_q;
    ext_e                  ext_q;
    logic [5:0]            sh;
    logic [31:0]           sra_w;
    logic                  flag_c;
    logic                  flag_q;
    logic                  pend_q;  // alu result due next edge
    logic                  mul_q;   // multiply in flight
    logic                  done_q;
    logic                  mul_go;
    logic                  mul_finish;

    function automatic logic [`EXEC_XLEN-1:0] extend(input logic [`EXEC_XLEN-1:0] v,
                                                     input ext_e e);
        case (e)
            EXT_SEXT32: extend = {{32{v[31]}}, v[31:0]};
            EXT_ZEXT32: extend = {32'b0, v[31:0]};
            EXT_SEXT16: extend = {{48{v[15]}}, v[15:0]};
            default:    extend = v;
        endcase
    endfunction

    assign a_in   = (cmd.width == W32) ? {32'b0, cmd.src1[31:0]} : cmd.src1;
    assign mul_go = cmd.start && (cmd.op == MUL);

    assign sh    = (width_q == W32) ? {1'b0, b_q[4:0]} : b_q[5:0];
    assign sra_w = $signed(a_q[31:0]) >>> sh;

    always_comb begin
        alu_res = a_q - b_q;  // compares keep the difference
        flag_c  = 1'b0;
        case (op_q)
            ADD:  alu_res = a_q + b_q;
            AND:  alu_res = a_q & b_q;
            OR:   alu_res = a_q | b_q;
            XOR:  alu_res = a_q ^ b_q;
            SLL:  alu_res = a_q << sh;
            SRL:  alu_res = a_q >> sh;
            SRA: begin
                if (width_q == W32)
                    alu_res = {{32{sra_w[31]}}, sra_w};
                else
                    alu_res = $signed(a_q) >>> sh;
            end
            SLT:  alu_res = {63'b0, $signed(a_q) < $signed(b_q)};
            SLTU: alu_res = {63'b0, a_q < b_q};
            DIVU: alu_res = (b_q == '0) ? '1 : a_q / b_q;   // div by zero gives all ones
            REMU: alu_res = (b_q == '0) ? a_q : a_q % b_q;
            MEM:  alu_res = b_q;  // narrowed by ext below
            CEQ:  flag_c = (a_q == b_q);
            CNE:  flag_c = (a_q != b_q);
            CLT:  flag_c = $signed(a_q) < $signed(b_q);
            CLTU: flag_c = a_q < b_q;
            CGE:  flag_c = $signed(a_q) >= $signed(b_q);
            CGEU: flag_c = a_q >= b_q;
            default: ;
        endcase
    end

    shift_add_mul u_mul (
        .clk          (clk),
        .reset        (reset),
        .go           (mul_go),
        .multiplicand (a_in),
        .multiplier   (cmd.src2),
        .product      (product),
        .finish       (mul_finish)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q <= 1'b0;
            mul_q  <= 1'b0;
            done_q <= 1'b0;
        end else if (cmd.start) begin
            pend_q <= (cmd.op != MUL);
            mul_q  <= (cmd.op == MUL);
            done_q <= 1'b0;
        end else if (pend_q) begin
            pend_q <= 1'b0;
            done_q <= 1'b1;
        end else if (mul_q && mul_finish) begin
            mul_q  <= 1'b0;
            done_q <= 1'b1;
        end else if (res.clear) begin
            done_q <= 1'b0;  // collector has it
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.start) begin
            op_q    <= cmd.op;
            width_q <= cmd.width;
            ext_q   <= cmd.ext;
            a_q     <= a_in;
            b_q     <= cmd.src2;
        end
        if (pend_q) begin
            result_q <= extend(alu_res, ext_q);
            flag_q   <= flag_c;
        end else if (mul_q && mul_finish) begin
            result_q <= extend(product, ext_q);
            flag_q   <= 1'b0;
        end
    end

    assign cmd.busy   = pend_q | mul_q;
    assign res.busy   = pend_q | mul_q;
    assign res.done   = done_q;
    assign res.result = result_q;
    assign res.flag   = flag_q;

endmodule

//--- hdl/result_collect.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module result_collect #(
    parameter int LANE_W = $clog2(`EXEC_LANES)
) (
    input  logic                    clk,
    input  logic                    reset,
    lane_res_if.coll                res [`EXEC_LANES],
    input  logic [LANE_W-1:0]       rd_lane,
    input  logic [2:0]              rd_reg,
    input  logic                    rd_en,
    output logic [`EXEC_DATA_W-1:0] prdata
);

    logic [`EXEC_LANES-1:0] done_v;
    logic [`EXEC_LANES-1:0] busy_v;
    logic [`EXEC_LANES-1:0] flag_v;
    logic [`EXEC_LANES-1:0] take;
    logic [`EXEC_LANES-1:0] clear_q;
    logic [`EXEC_LANES-1:0] sticky_q;
    logic [`EXEC_LANES-1:0] flag_q;
    logic [`EXEC_XLEN-1:0]  result_v [`EXEC_LANES];
    logic [`EXEC_XLEN-1:0]  res_q    [`EXEC_LANES];

    for (genvar g = 0; g < `EXEC_LANES; g++) begin : g_res
        assign done_v[g]   = res[g].done;
        assign busy_v[g]   = res[g].busy;
        assign flag_v[g]   = res[g].flag;
        assign result_v[g] = res[g].result;
        assign res[g].clear = clear_q[g];
    end

    // capture once per done, clear_q masks the second done cycle
    assign take = done_v & ~clear_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            clear_q  <= '0;
            sticky_q <= '0;
            flag_q   <= '0;
        end else begin
            clear_q <= take;
            for (int i = 0; i < `EXEC_LANES; i++) begin
                if (take[i]) begin
                    sticky_q[i] <= 1'b1;
                    flag_q[i]   <= flag_v[i];
                end else if (rd_en && rd_reg == 3'd7 && rd_lane == LANE_W'(i)) begin
                    sticky_q[i] <= 1'b0;  // high word read consumes it
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `EXEC_LANES; i++) begin
            if (take[i])
                res_q[i] <= result_v[i];
        end
    end

    always_comb begin
        prdata = '0;
        if (rd_en) begin
            case (rd_reg)
                3'd1: prdata[2:0] = {flag_q[rd_lane], sticky_q[rd_lane], busy_v[rd_lane]};
                3'd6: prdata = res_q[rd_lane][31:0];
                3'd7: prdata = res_q[rd_lane][63:32];
                default: ;  // write-only offsets read as zero
            endcase
        end
    end

endmodule

//--- hdl/exec_top.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`EXEC_ADDR_W-1:0] paddr,
    input  logic [`EXEC_DATA_W-1:0] pwdata,
    output logic [`EXEC_DATA_W-1:0] prdata,
    output logic                    pready,
    output logic                    pslverr
);

    localparam int LANE_W = $clog2(`EXEC_LANES);

    logic [LANE_W-1:0] rd_lane;
    logic [2:0]        rd_reg;
    logic              rd_en;

    lane_cmd_if cmd_bus [`EXEC_LANES] ();
    lane_res_if res_bus [`EXEC_LANES] ();

    apb_dispatch #(
        .LANE_W (LANE_W)
    ) u_dispatch (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cmd     (cmd_bus),
        .rd_lane (rd_lane),
        .rd_reg  (rd_reg),
        .rd_en   (rd_en)
    );

    for (genvar g = 0; g < `EXEC_LANES; g++) begin : g_lane
        exec_lane u_lane (
            .clk   (clk),
            .reset (reset),
            .cmd   (cmd_bus[g]),
            .res   (res_bus[g])
        );
    end

    result_collect #(
        .LANE_W (LANE_W)
    ) u_collect (
        .clk     (clk),
        .reset   (reset),
        .res     (res_bus),
        .rd_lane (rd_lane),
        .rd_reg  (rd_reg),
        .rd_en   (rd_en),
        .prdata  (prdata)
    );

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD       = 4,   // ns
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // sync reset, released just after an edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

//--- testbench/exec_tb.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_tb
    import exec_pkg::*;
();

    localparam int MAX_ROWS = 128;
    localparam logic [63:0] MSB = 64'h8000_0000_0000_0000;

    typedef struct packed {
        int                    lane;
        alu_op_e               op;
        width_e                width;
        ext_e                  ext;
        logic [`EXEC_XLEN-1:0] src1;
        logic [`EXEC_XLEN-1:0] src2;
        logic [`EXEC_XLEN-1:0] exp_res;
        logic                  exp_flag;
        logic                  conc;  // issued together in the multi-lane phase
    } row_t;

    logic                    clk;
    logic                    reset;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`EXEC_ADDR_W-1:0] paddr;
    logic [`EXEC_DATA_W-1:0] pwdata;
    logic [`EXEC_DATA_W-1:0] prdata;
    logic                    pready;
    logic                    pslverr;

    row_t rows     [MAX_ROWS];
    int   err_mark [MAX_ROWS];
    int   nrows;
    int   errors;
    int   tests;
    int   passed;
    int   limit;
    int   cycle_cnt;
    int   last_conc;

    tb_clkgen #(.PERIOD(4), .RESET_CYCLES(16)) u_clk (.clk(clk), .reset(reset));

    exec_top UUT (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // golden model straight from the op definitions
    function automatic void ref_alu(input alu_op_e op, input width_e w, input ext_e e,
                                    input logic [63:0] s1, input logic [63:0] s2,
                                    output logic [63:0] res, output logic flg);
        logic [63:0] a;
        logic [31:0] lo;
        int unsigned sh;
        logic        lt_s;
        a    = (w == W32) ? (s1 & 64'h0000_0000_ffff_ffff) : s1;
        sh   = (w == W32) ? int'(s2[4:0]) : int'(s2[5:0]);
        lt_s = (a ^ MSB) < (s2 ^ MSB);  // bias trick for signed order
        flg  = 1'b0;
        res  = a - s2;
        case (op)
            ADD:  res = a + s2;
            AND:  res = a & s2;
            OR:   res = a | s2;
            XOR:  res = a ^ s2;
            SLL:  res = a << sh;
            SRL:  res = a >> sh;
            SRA: begin
                if (w == W32) begin
                    lo  = (a[31:0] >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
                    res = {{32{lo[31]}}, lo};
                end else begin
                    res = (a >> sh) | (a[63] ? ~(64'hffff_ffff_ffff_ffff >> sh) : 64'h0);
                end
            end
            SLT:  res = lt_s ? 64'd1 : 64'd0;
            SLTU: res = (a < s2) ? 64'd1 : 64'd0;
            DIVU: res = (s2 == 64'h0) ? 64'hffff_ffff_ffff_ffff : a / s2;
            REMU: res = (s2 == 64'h0) ? a : a - (a / s2) * s2;
            MUL:  res = a * s2;  // low half
            MEM:  res = s2;
            CEQ:  flg = (a == s2);
            CNE:  flg = (a != s2);
            CLT:  flg = lt_s;
            CLTU: flg = (a < s2);
            CGE:  flg = !lt_s;
            CGEU: flg = !(a < s2);
            default: ;
        endcase
        case (e)
            EXT_SEXT32: res = {{32{res[31]}}, res[31:0]};
            EXT_ZEXT32: res = {32'h0, res[31:0]};
            EXT_SEXT16: res = {{48{res[15]}}, res[15:0]};
            default: ;
        endcase
    endfunction

    function automatic logic [63:0] rnd64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [31:0] ctrl_word(input alu_op_e op, input width_e w,
                                              input ext_e e);
        return {18'h0, e, 3'h0, w, 3'h0, op};
    endfunction

    task automatic add_row(input logic conc, input int lane, input alu_op_e op,
                           input width_e w, input ext_e e,
                           input logic [63:0] s1, input logic [63:0] s2);
        logic [63:0] r;
        logic        f;
        ref_alu(op, w, e, s1, s2, r, f);
        rows[nrows] = '{lane: lane, op: op, width: w, ext: e, src1: s1, src2: s2,
                        exp_res: r, exp_flag: f, conc: conc};
        nrows++;
    endtask

    task automatic build_table();
        alu_op_e     b1_ops [7];
        alu_op_e     sh_ops [3];
        alu_op_e     cmp_ops [6];
        int          amt [4];
        logic [63:0] pa [3];
        logic [63:0] pb [3];
        logic [63:0] v;
        b1_ops  = '{ADD, SUB, AND, OR, XOR, SLT, SLTU};
        sh_ops  = '{SLL, SRL, SRA};
        cmp_ops = '{CEQ, CNE, CLT, CLTU, CGE, CGEU};
        amt     = '{0, 31, 32, 63};
        v       = rnd64();
        pa      = '{v, 64'h8000_0000_0000_0005, 64'h3};  // equal, signed-less, unsigned-less
        pb      = '{v, 64'h7, 64'hffff_ffff_ffff_fff0};
        foreach (b1_ops[k])
            for (int w = 0; w < 2; w++)
                for (int e = 0; e < 4; e++)
                    add_row(1'b0, nrows % `EXEC_LANES, b1_ops[k], width_e'(w), ext_e'(e),
                            rnd64(), rnd64());
        foreach (sh_ops[k])
            for (int w = 0; w < 2; w++)
                foreach (amt[j]) begin
                    v = rnd64();
                    add_row(1'b0, nrows % `EXEC_LANES, sh_ops[k], width_e'(w), EXT_NONE,
                            rnd64() | MSB, {v[63:6], 6'(amt[j])});  // msb set for sra fill
                end
        foreach (cmp_ops[k])
            for (int j = 0; j < 3; j++)
                add_row(1'b0, nrows % `EXEC_LANES, cmp_ops[k], W64, EXT_NONE, pa[j], pb[j]);
        add_row(1'b0, nrows % `EXEC_LANES, DIVU, W64, EXT_NONE, rnd64(), rnd64() >> 32);
        add_row(1'b0, nrows % `EXEC_LANES, REMU, W64, EXT_NONE, rnd64(), rnd64() >> 32);
        add_row(1'b0, nrows % `EXEC_LANES, DIVU, W64, EXT_NONE, rnd64(), 64'h0);
        add_row(1'b0, nrows % `EXEC_LANES, REMU, W64, EXT_NONE, rnd64(), 64'h0);
        for (int e = 0; e < 4; e++)
            add_row(1'b0, nrows % `EXEC_LANES, MEM, W64, ext_e'(e), rnd64(), rnd64());
        add_row(1'b0, nrows % `EXEC_LANES, MUL, W64, EXT_NONE, rnd64(), rnd64());
        add_row(1'b0, nrows % `EXEC_LANES, MUL, W32, EXT_SEXT32, rnd64(), rnd64());
        add_row(1'b0, nrows % `EXEC_LANES, MUL, W64, EXT_ZEXT32, rnd64(), rnd64());
        for (int l = 0; l < `EXEC_LANES; l++) begin
            last_conc = nrows;
            add_row(1'b1, l, MUL, W64, EXT_NONE, rnd64(), rnd64());
        end
    endtask

    task automatic check_ready(input logic [`EXEC_ADDR_W-1:0] addr, input logic got);
        if (got !== 1'b1) begin
            $display("[FAIL] %0t pready %b at address %h expected 1", $time, got, addr);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [`EXEC_ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;
        #1 err = pslverr;  // mid access phase
        check_ready(addr, pready);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`EXEC_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1 penable = 1'b1;
        #1 data = prdata;
        check_ready(addr, pready);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_result(input int row, input alu_op_e op,
                                input logic [`EXEC_XLEN-1:0] got,
                                input logic [`EXEC_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t row %0d %s result %h expected %h",
                     $time, row, op.name(), got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input int row, input alu_op_e op, input logic got,
                              input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t row %0d %s flag %b expected %b",
                     $time, row, op.name(), got, exp);
            errors++;
        end
    endtask

    task automatic issue_row(input int i);
        logic [7:0] base;
        logic       err;
        base        = 8'(rows[i].lane * 32);
        err_mark[i] = errors;
        apb_write(base + 8'h08, rows[i].src1[31:0], err);
        apb_write(base + 8'h0c, rows[i].src1[63:32], err);
        apb_write(base + 8'h10, rows[i].src2[31:0], err);
        apb_write(base + 8'h14, rows[i].src2[63:32], err);
        apb_write(base, ctrl_word(rows[i].op, rows[i].width, rows[i].ext), err);
        if (err) begin
            $display("row %0d: control write to idle lane %0d was answered with pslverr",
                     i, rows[i].lane);
            errors++;
        end
    endtask

    task automatic collect_row(input int i);
        logic [7:0]  base;
        logic [31:0] st;
        logic [31:0] lo;
        logic [31:0] hi;
        logic        flg;
        base = 8'(rows[i].lane * 32);
        st   = '0;
        while (!st[1]) begin
            apb_read(base + 8'h04, st);
            if (st[0] && st[1]) begin
                $display("row %0d: done flag was set while the lane was still busy", i);
                errors++;
            end
        end
        flg = st[2];
        apb_read(base + 8'h18, lo);
        apb_read(base + 8'h1c, hi);
        check_result(i, rows[i].op, {hi, lo}, rows[i].exp_res);
        check_flag(i, rows[i].op, flg, rows[i].exp_flag);
        apb_read(base + 8'h04, st);
        if (st[1]) begin
            $display("row %0d: done flag was not cleared by the high word read", i);
            errors++;
        end
        tests++;
        if (errors == err_mark[i])
            passed++;
        $display("row %0d lane %0d %s %s %s %s", i, rows[i].lane, rows[i].op.name(),
                 rows[i].width.name(), rows[i].ext.name(),
                 (errors == err_mark[i]) ? "ok" : "failed");
    endtask

    // a running lane keeps its multiply when its control is rewritten
    task automatic busy_reject(input int i);
        logic [7:0] base;
        logic       err;
        base = 8'(rows[i].lane * 32);
        apb_write(base + 8'h08, 32'hdead_beef, err);
        apb_write(base, ctrl_word(ADD, W64, EXT_NONE), err);
        tests++;
        if (err) begin
            passed++;
            $display("busy lane %0d rewrite rejected ok", rows[i].lane);
        end else begin
            $display("control write to busy lane %0d was not rejected with pslverr",
                     rows[i].lane);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (limit > 0 && cycle_cnt >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        nrows     = 0;
        errors    = 0;
        tests     = 0;
        passed    = 0;
        limit     = 0;
        cycle_cnt = 0;
        last_conc = 0;
        void'($urandom(32'h47e9));
        build_table();
        limit = nrows * (`MUL_STEPS + 20);
        @(posedge clk);
        wait (reset == 1'b0);
        for (int i = 0; i < nrows; i++) begin
            if (!rows[i].conc) begin
                issue_row(i);
                collect_row(i);
            end
        end
        // every lane multiplies at once
        for (int i = 0; i < nrows; i++)
            if (rows[i].conc)
                issue_row(i);
        busy_reject(last_conc);
        for (int i = 0; i < nrows; i++)
            if (rows[i].conc)
                collect_row(i);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, passed, tests - passed, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/exec_pkg.sv
hdl/lane_if.sv
hdl/apb_dispatch.sv
hdl/shift_add_mul.sv
hdl/exec_lane.sv
hdl/result_collect.sv
hdl/exec_top.sv
testbench/tb_clkgen.sv
testbench/exec_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f flist.f --top-module exec_tb --Mdir obj_dir -o exec_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/exec_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
